// ==== source/chan_cfg_pkg.sv ====
package chan_cfg_pkg;

  // data memory geometry
  localparam int ADDR_W     = 8;
  localparam int DATA_DEPTH = 256;   // words, two samples per word

  localparam int WORD_W   = 32;      // stream and memory word
  localparam int SAMPLE_W = 13;      // 12 data bits plus over-range in the lsb

  // header queue depth in words, two words per event
  localparam int HDR_DEPTH = 8;

  // configuration register selectors
  localparam logic [3:0] REG_BUFFER_SIZE = 4'd0;
  localparam logic [3:0] REG_POST_TRIG   = 4'd1;
  localparam logic [3:0] REG_CHANNEL_NUM = 4'd2;
  localparam logic [3:0] REG_TRIG_NUM    = 4'd3;

  typedef logic [ADDR_W-1:0] addr_t;   // data memory address
  typedef logic [WORD_W-1:0] word_t;   // one 32-bit word

endpackage

// ==== source/chan_cmd_pkg.sv ====
package chan_cmd_pkg;

  // opcode sits in the top nibble of every command
  localparam logic [3:0] OP_WRITE_REG = 4'd1;
  localparam logic [3:0] OP_READOUT   = 4'd2;

  // single word returned when the header queue is empty
  localparam logic [31:0] STATUS_NO_EVENT = 32'hF000_0000;

  ////////////////////////////////////////
  // command word, decoded by opcode
  ////////////////////////////////////////
  typedef union packed {
    // register write
    struct packed {
      logic [3:0]  opcode;
      logic [3:0]  sel;     // register selector
      logic [23:0] value;   // zero-extended into the target
    } wr;
    // readout request
    struct packed {
      logic [3:0]  opcode;
      logic [15:0] rsvd;
      logic [11:0] count;   // data words wanted
    } rd;
  } cmd_word_t;

endpackage

// ==== source/command_decoder.sv ====
`timescale 1ns/1ps

module command_decoder (
  input  logic                          clk,
  input  logic                          reset,
  input  chan_cfg_pkg::word_t           rx_data,
  input  logic                          rx_valid,
  output logic                          rx_ready,
  input  logic                          readout_busy,
  output logic [chan_cfg_pkg::ADDR_W:0] buffer_size,
  output chan_cfg_pkg::addr_t           post_trig_size,
  output logic [15:0]                   channel_num,
  output chan_cfg_pkg::word_t           init_trig_num,
  output logic                          trig_num_load,
  output logic                          readout_req,
  output logic [11:0]                   req_count
);
  import chan_cfg_pkg::*;
  import chan_cmd_pkg::*;

  cmd_word_t   cmd;
  logic        rx_fire;
  logic [11:0] count_lim;

  assign rx_ready  = ~readout_busy;   // stall commands while a readout runs
  assign rx_fire   = rx_valid & rx_ready;
  assign cmd       = rx_data;
  assign count_lim = 12'(buffer_size);   // never read more than the ring holds

  always_ff @(posedge clk) begin
    if (reset) begin
      buffer_size    <= (ADDR_W+1)'(DATA_DEPTH);
      post_trig_size <= addr_t'(16);
      channel_num    <= '0;
      init_trig_num  <= '0;
      trig_num_load  <= 1'b0;
      readout_req    <= 1'b0;
      req_count      <= '0;
    end else begin
      trig_num_load <= 1'b0;   // strobes last one clock
      readout_req   <= 1'b0;
      if (rx_fire) begin
        case (cmd.wr.opcode)
          OP_WRITE_REG: begin
            case (cmd.wr.sel)
              REG_BUFFER_SIZE: buffer_size    <= cmd.wr.value[ADDR_W:0];
              REG_POST_TRIG:   post_trig_size <= cmd.wr.value[ADDR_W-1:0];
              REG_CHANNEL_NUM: channel_num    <= cmd.wr.value[15:0];
              REG_TRIG_NUM: begin
                init_trig_num <= word_t'(cmd.wr.value);
                trig_num_load <= 1'b1;   // controller reloads its event count
              end
              default: ;   // unknown selector
            endcase
          end
          OP_READOUT: begin
            readout_req <= 1'b1;
            req_count   <= (cmd.rd.count > count_lim) ? count_lim : cmd.rd.count;
          end
          default: ;   // other opcodes dropped
        endcase
      end
    end
  end

endmodule

// ==== source/acq_controller.sv ====
`timescale 1ns/1ps

module acq_controller (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              acq_arm,    // async level
  input  logic                              acq_trig,   // async level
  output logic                              acq_done,
  input  logic [chan_cfg_pkg::SAMPLE_W-1:0] sample_a,
  input  logic [chan_cfg_pkg::SAMPLE_W-1:0] sample_b,
  input  logic [chan_cfg_pkg::ADDR_W:0]     buffer_size,
  input  chan_cfg_pkg::addr_t               post_trig_size,
  input  logic [15:0]                       channel_num,
  input  chan_cfg_pkg::word_t               init_trig_num,
  input  logic                              trig_num_load,
  output logic                              mem_we,
  output chan_cfg_pkg::addr_t               mem_waddr,
  output chan_cfg_pkg::word_t               mem_wdata,
  output logic                              hdr_push,
  output chan_cfg_pkg::word_t               hdr_din
);
  import chan_cfg_pkg::*;

  enum logic [2:0] {S_IDLE, S_WRITING, S_POST, S_HEADER0, S_HEADER1, S_DONE} state;

  logic [1:0] sync_q0;     // {trig, arm} first stage
  logic [1:0] sync_q1;     // {trig, arm} second stage
  logic       trig_d;
  logic       arm_s;
  logic       trig_rise;
  logic       wrap;
  addr_t      waddr;
  addr_t      last_addr;
  addr_t      post_cnt;
  word_t      trig_num;

  // 13-bit sample to 16 bits, sign bit is the msb
  function automatic logic [WORD_W/2-1:0] sext(input logic [SAMPLE_W-1:0] s);
    return {{(WORD_W/2-SAMPLE_W){s[SAMPLE_W-1]}}, s};
  endfunction

  ////////////////////////////////////////
  // arm and trigger synchronizers
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      sync_q0 <= '0;
      sync_q1 <= '0;
      trig_d  <= 1'b0;
    end else begin
      sync_q0 <= {acq_trig, acq_arm};
      sync_q1 <= sync_q0;
      trig_d  <= sync_q1[1];   // for edge detect
    end
  end

  assign arm_s     = sync_q1[0];
  assign trig_rise = sync_q1[1] & ~trig_d;

  ////////////////////////////////////////
  // packing and ring write
  ////////////////////////////////////////
  assign mem_wdata = {sext(sample_b), sext(sample_a)};   // sample_a in the low half
  assign mem_we    = (state == S_WRITING) || (state == S_POST);
  assign mem_waddr = waddr;
  assign wrap      = ({1'b0, waddr} == buffer_size - 1'b1);

  // header words pushed back to back
  assign hdr_push = (state == S_HEADER0) || (state == S_HEADER1);
  assign hdr_din  = (state == S_HEADER0) ? trig_num :
                    {channel_num, {(WORD_W/2-ADDR_W){1'b0}}, last_addr};
  assign acq_done = (state == S_DONE);

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= S_IDLE;
      waddr     <= '0;
      last_addr <= '0;
      post_cnt  <= '0;
      trig_num  <= '0;
    end else begin
      if (mem_we) begin
        waddr     <= wrap ? '0 : waddr + 1'b1;
        last_addr <= waddr;   // newest word in the ring
      end
      case (state)
        S_IDLE: begin
          waddr <= '0;   // every arm starts at the bottom
          if (arm_s) state <= S_WRITING;
        end
        S_WRITING: begin
          if (!arm_s) begin
            state <= S_IDLE;
          end else if (trig_rise) begin
            post_cnt <= post_trig_size;
            state    <= (post_trig_size == '0) ? S_HEADER0 : S_POST;
          end
        end
        S_POST: begin
          post_cnt <= post_cnt - 1'b1;
          if (!arm_s) state <= S_IDLE;   // disarmed mid event, no header
          else if (post_cnt == addr_t'(1)) state <= S_HEADER0;
        end
        S_HEADER0: state <= S_HEADER1;
        S_HEADER1: state <= arm_s ? S_DONE : S_IDLE;
        S_DONE: begin
          if (!arm_s) state <= S_IDLE;   // done held until disarm
        end
        default: state <= S_IDLE;
      endcase
      // event number
      if (trig_num_load) trig_num <= init_trig_num;
      else if (state == S_HEADER1) trig_num <= trig_num + 1'b1;
    end
  end

endmodule

// ==== source/event_store.sv ====
`timescale 1ns/1ps

module event_store (
  input  logic                clk,
  input  logic                reset,
  input  logic                mem_we,
  input  chan_cfg_pkg::addr_t mem_waddr,
  input  chan_cfg_pkg::word_t mem_wdata,
  input  chan_cfg_pkg::addr_t mem_raddr,
  output chan_cfg_pkg::word_t mem_rdata,
  input  logic                hdr_push,
  input  chan_cfg_pkg::word_t hdr_din,
  input  logic                hdr_pop,
  output chan_cfg_pkg::word_t hdr_dout,
  output logic                hdr_empty
);
  import chan_cfg_pkg::*;

  word_t data_mem [DATA_DEPTH];
  word_t hdr_mem  [HDR_DEPTH];

  logic [$clog2(HDR_DEPTH)-1:0] wr_ptr;
  logic [$clog2(HDR_DEPTH)-1:0] rd_ptr;
  logic [$clog2(HDR_DEPTH):0]   hdr_count;
  logic pair_odd;     // next push is the second word of an event
  logic pair_ok;      // first word of this event was kept
  logic first_fits;
  logic push_ok;
  logic pop_ok;

  // data ring, one cycle read latency
  always_ff @(posedge clk) begin
    if (mem_we) data_mem[mem_waddr] <= mem_wdata;
    mem_rdata <= data_mem[mem_raddr];
  end

  ////////////////////////////////////////
  // header queue, first word falls through
  ////////////////////////////////////////
  assign first_fits = (hdr_count <= HDR_DEPTH - 2);   // room for a whole event
  assign push_ok    = hdr_push & (pair_odd ? pair_ok : first_fits);
  assign pop_ok     = hdr_pop & ~hdr_empty;
  assign hdr_empty  = (hdr_count == '0);
  assign hdr_dout   = hdr_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push_ok) hdr_mem[wr_ptr] <= hdr_din;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      hdr_count <= '0;
      pair_odd  <= 1'b0;
      pair_ok   <= 1'b0;
    end else begin
      if (hdr_push) begin
        pair_odd <= ~pair_odd;
        if (!pair_odd) pair_ok <= first_fits;   // both words share one decision
      end
      if (push_ok) wr_ptr <= wr_ptr + 1'b1;
      if (pop_ok) rd_ptr <= rd_ptr + 1'b1;
      case ({push_ok, pop_ok})
        2'b10:   hdr_count <= hdr_count + 1'b1;
        2'b01:   hdr_count <= hdr_count - 1'b1;
        default: ;
      endcase
    end
  end

endmodule

// ==== source/readout_engine.sv ====
`timescale 1ns/1ps

module readout_engine (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          readout_req,
  input  logic [11:0]                   req_count,
  input  logic [chan_cfg_pkg::ADDR_W:0] buffer_size,
  output logic                          readout_busy,
  output chan_cfg_pkg::addr_t           mem_raddr,
  input  chan_cfg_pkg::word_t           mem_rdata,
  input  chan_cfg_pkg::word_t           hdr_dout,
  output logic                          hdr_pop,
  input  logic                          hdr_empty,
  output chan_cfg_pkg::word_t           tx_data,
  output logic                          tx_valid,
  output logic                          tx_last,
  input  logic                          tx_ready
);
  import chan_cfg_pkg::*;
  import chan_cmd_pkg::*;

  enum logic [2:0] {S_IDLE, S_STATUS, S_HDR0, S_HDR1, S_DATA} state;

  addr_t           rd_addr;      // address behind mem_rdata
  addr_t           next_addr;
  addr_t           start_addr;
  logic [11:0]     remain;       // data words still to load
  logic [ADDR_W:0] last_ext;
  logic [ADDR_W:0] back;         // distance from oldest to newest word
  logic            accept;
  logic            load_data;

  assign accept       = tx_valid & tx_ready;
  assign load_data    = accept & ~tx_last & ((state == S_HDR1) || (state == S_DATA));
  assign readout_busy = readout_req | (state != S_IDLE);
  assign hdr_pop      = ((state == S_IDLE) & readout_req & ~hdr_empty) |
                        ((state == S_HDR0) & accept);

  ////////////////////////////////////////
  // oldest address, taken from header word 1
  ////////////////////////////////////////
  assign last_ext   = {1'b0, hdr_dout[ADDR_W-1:0]};
  assign back       = (remain == '0) ? '0 : (ADDR_W+1)'(remain - 1'b1);
  assign start_addr = (last_ext >= back) ? addr_t'(last_ext - back)
                                         : addr_t'(last_ext + buffer_size - back);
  assign next_addr  = ({1'b0, rd_addr} == buffer_size - 1'b1) ? '0 : rd_addr + 1'b1;

  // memory runs one word ahead of tx
  always_comb begin
    mem_raddr = rd_addr;
    if (state == S_HDR0) mem_raddr = start_addr;
    else if (load_data) mem_raddr = next_addr;
  end

  always_ff @(posedge clk) begin
    if (state == S_IDLE && readout_req) tx_data <= hdr_empty ? STATUS_NO_EVENT : hdr_dout;
    else if (state == S_HDR0 && accept) tx_data <= hdr_dout;   // header word 1
    else if (load_data) tx_data <= mem_rdata;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= S_IDLE;
      tx_valid <= 1'b0;
      tx_last  <= 1'b0;
      remain   <= '0;
      rd_addr  <= '0;
    end else begin
      rd_addr <= mem_raddr;
      case (state)
        S_IDLE: begin
          if (readout_req) begin
            remain   <= req_count;
            tx_valid <= 1'b1;
            tx_last  <= hdr_empty;   // status word is a one word reply
            state    <= hdr_empty ? S_STATUS : S_HDR0;
          end
        end
        S_STATUS: begin
          if (accept) begin
            tx_valid <= 1'b0;
            tx_last  <= 1'b0;
            state    <= S_IDLE;
          end
        end
        S_HDR0: begin
          if (accept) begin
            tx_last <= (remain == '0);   // header ends it if no data asked
            state   <= S_HDR1;
          end
        end
        S_HDR1, S_DATA: begin
          if (accept && tx_last) begin
            tx_valid <= 1'b0;
            tx_last  <= 1'b0;
            state    <= S_IDLE;
          end else if (load_data) begin
            remain  <= remain - 1'b1;
            tx_last <= (remain == 12'd1);
            state   <= S_DATA;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

// ==== source/channel_core.sv ====
`timescale 1ns/1ps

module channel_core (
  input  logic                              clk,
  input  logic                              reset,
  input  logic [chan_cfg_pkg::SAMPLE_W-1:0] sample_a,
  input  logic [chan_cfg_pkg::SAMPLE_W-1:0] sample_b,
  input  logic                              acq_arm,
  input  logic                              acq_trig,
  output logic                              acq_done,
  input  chan_cfg_pkg::word_t               rx_data,
  input  logic                              rx_valid,
  input  logic                              rx_last,    // commands are single words
  output logic                              rx_ready,
  output chan_cfg_pkg::word_t               tx_data,
  output logic                              tx_valid,
  output logic                              tx_last,
  input  logic                              tx_ready
);
  import chan_cfg_pkg::*;

  // configuration
  logic [ADDR_W:0] buffer_size;
  addr_t           post_trig_size;
  logic [15:0]     channel_num;
  word_t           init_trig_num;
  logic            trig_num_load;
  // readout control
  logic            readout_req;
  logic [11:0]     req_count;
  logic            readout_busy;
  // memory and header queue
  logic            mem_we;
  addr_t           mem_waddr;
  word_t           mem_wdata;
  addr_t           mem_raddr;
  word_t           mem_rdata;
  logic            hdr_push;
  word_t           hdr_din;
  logic            hdr_pop;
  word_t           hdr_dout;
  logic            hdr_empty;

  command_decoder u_command_decoder (
    .clk            (clk),
    .reset          (reset),
    .rx_data        (rx_data),
    .rx_valid       (rx_valid),
    .rx_ready       (rx_ready),
    .readout_busy   (readout_busy),
    .buffer_size    (buffer_size),
    .post_trig_size (post_trig_size),
    .channel_num    (channel_num),
    .init_trig_num  (init_trig_num),
    .trig_num_load  (trig_num_load),
    .readout_req    (readout_req),
    .req_count      (req_count)
  );

  acq_controller u_acq_controller (
    .clk            (clk),
    .reset          (reset),
    .acq_arm        (acq_arm),
    .acq_trig       (acq_trig),
    .acq_done       (acq_done),
    .sample_a       (sample_a),
    .sample_b       (sample_b),
    .buffer_size    (buffer_size),
    .post_trig_size (post_trig_size),
    .channel_num    (channel_num),
    .init_trig_num  (init_trig_num),
    .trig_num_load  (trig_num_load),
    .mem_we         (mem_we),
    .mem_waddr      (mem_waddr),
    .mem_wdata      (mem_wdata),
    .hdr_push       (hdr_push),
    .hdr_din        (hdr_din)
  );

  event_store u_event_store (
    .clk       (clk),
    .reset     (reset),
    .mem_we    (mem_we),
    .mem_waddr (mem_waddr),
    .mem_wdata (mem_wdata),
    .mem_raddr (mem_raddr),
    .mem_rdata (mem_rdata),
    .hdr_push  (hdr_push),
    .hdr_din   (hdr_din),
    .hdr_pop   (hdr_pop),
    .hdr_dout  (hdr_dout),
    .hdr_empty (hdr_empty)
  );

  readout_engine u_readout_engine (
    .clk          (clk),
    .reset        (reset),
    .readout_req  (readout_req),
    .req_count    (req_count),
    .buffer_size  (buffer_size),
    .readout_busy (readout_busy),
    .mem_raddr    (mem_raddr),
    .mem_rdata    (mem_rdata),
    .hdr_dout     (hdr_dout),
    .hdr_pop      (hdr_pop),
    .hdr_empty    (hdr_empty),
    .tx_data      (tx_data),
    .tx_valid     (tx_valid),
    .tx_last      (tx_last),
    .tx_ready     (tx_ready)
  );

endmodule

// ==== tb/channel_core_chk.sv ====
`timescale 1ns/1ps

module channel_core_chk (
  input logic                clk,
  input logic                reset,
  input logic                acq_arm,
  input logic                acq_done,
  input chan_cfg_pkg::word_t tx_data,
  input logic                tx_valid,
  input logic                tx_last,
  input logic                tx_ready
);

  // a stalled tx word stays put until taken
  tx_hold: assert property (@(posedge clk) disable iff (reset)
    (tx_valid && !tx_ready) |=> (tx_valid && $stable(tx_data) && $stable(tx_last)))
    else $error("tx word changed while stalled");

  tx_idle_after_reset: assert property (@(posedge clk) reset |=> !tx_valid)
    else $error("tx_valid high after reset");

  // 2 sync flops plus the state change
  done_clear: assert property (@(posedge clk) disable iff (reset)
    !acq_arm |-> ##3 !acq_done)
    else $error("acq_done still high after disarm");

endmodule

bind channel_core channel_core_chk u_chk (
  .clk      (clk),
  .reset    (reset),
  .acq_arm  (acq_arm),
  .acq_done (acq_done),
  .tx_data  (tx_data),
  .tx_valid (tx_valid),
  .tx_last  (tx_last),
  .tx_ready (tx_ready)
);

// ==== tb/channel_core_tb.sv ====
`timescale 1ns/1ps

module channel_core_tb;
  import chan_cfg_pkg::*;
  import chan_cmd_pkg::*;

  localparam logic [11:0] CNT_IDLE = 12'd1944;   // count held while disarmed
  localparam int BUF_WORDS = 64;
  localparam int TIMEOUT   = 2000;                 // cycles per wait

  logic                clk = 1'b0;
  logic                reset;
  logic [SAMPLE_W-1:0] sample_a;
  logic [SAMPLE_W-1:0] sample_b;
  logic                acq_arm;
  logic                acq_trig;
  logic                acq_done;
  word_t               rx_data;
  logic                rx_valid;
  logic                rx_last;
  logic                rx_ready;
  word_t               tx_data;
  logic                tx_valid;
  logic                tx_last;
  logic                tx_ready;

  logic [11:0] sample_cnt;
  integer      seed;
  int          errors;
  int          failed_tests;
  logic        reply_last;   // tx_last seen on the final word
  word_t       reply[$];     // words of the latest tx reply
  word_t       saved[$];     // first event's reply, for the stall replay

  channel_core u_dut (
    .clk      (clk),
    .reset    (reset),
    .sample_a (sample_a),
    .sample_b (sample_b),
    .acq_arm  (acq_arm),
    .acq_trig (acq_trig),
    .acq_done (acq_done),
    .rx_data  (rx_data),
    .rx_valid (rx_valid),
    .rx_last  (rx_last),
    .rx_ready (rx_ready),
    .tx_data  (tx_data),
    .tx_valid (tx_valid),
    .tx_last  (tx_last),
    .tx_ready (tx_ready)
  );

  always #2 clk = ~clk;   // 4 ns period

  // sample counter restarts on every arm, so equal events give equal data
  always @(posedge clk) begin
    sample_cnt <= acq_arm ? sample_cnt + 1'b1 : CNT_IDLE;
  end
  assign sample_a = {sample_cnt, 1'b0};   // twice the count
  assign sample_b = {sample_cnt, 1'b1};   // twice the count plus 1

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////
  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s = %b, expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  // both samples of one count, each 13 bits sign-extended to 16
  function automatic word_t packed_word(input logic [11:0] cnt);
    logic [SAMPLE_W-1:0] a;
    logic [SAMPLE_W-1:0] b;
    a = {cnt, 1'b0};
    b = {cnt, 1'b1};
    return {{3{b[SAMPLE_W-1]}}, b, {3{a[SAMPLE_W-1]}}, a};
  endfunction

  function automatic word_t write_cmd(input logic [3:0] sel, input logic [23:0] value);
    return {OP_WRITE_REG, sel, value};
  endfunction

  function automatic word_t read_cmd(input logic [11:0] count);
    return {OP_READOUT, 16'h0000, count};
  endfunction

  ////////////////////////////////////////
  // stream and acquisition helpers
  ////////////////////////////////////////
  task automatic send_cmd(input word_t w);
    int n;
    n = 0;
    @(posedge clk);
    rx_data  <= w;
    rx_valid <= 1'b1;
    rx_last  <= 1'b1;   // every command is one word
    do begin
      @(posedge clk);
      n++;
    end while (!rx_ready && n < TIMEOUT);
    rx_valid <= 1'b0;
    rx_last  <= 1'b0;
    if (!rx_ready) begin
      $display("timeout: command word %h was never accepted", w);
      errors++;
    end
  endtask

  // collect tx words up to tx_last, optionally with random stalls
  task automatic get_reply(input bit stall);
    int n;
    n = 0;
    reply_last = 1'b0;
    reply.delete();
    while (!reply_last && n < TIMEOUT) begin
      @(posedge clk);
      n++;
      if (tx_valid && tx_ready) begin
        reply.push_back(tx_data);
        reply_last = tx_last;
      end
      tx_ready <= stall ? (($random(seed) & 3) != 0) : 1'b1;
    end
    tx_ready <= 1'b1;
    if (!reply_last) begin
      $display("timeout: tx reply never ended with tx_last");
      errors++;
    end else begin
      @(posedge clk);
      check_flag("tx_valid after tx_last", tx_valid, 1'b0);   // nothing follows the last word
    end
  endtask

  task automatic wait_done(input logic level);
    int n;
    n = 0;
    while (acq_done !== level && n < TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    if (acq_done !== level) begin
      $display("timeout: acq_done never went to %0b", level);
      errors++;
    end
  endtask

  task automatic run_event();
    @(posedge clk);
    acq_arm <= 1'b1;
    repeat (100) @(posedge clk);   // ring fills and wraps before the trigger
    acq_trig <= 1'b1;
    wait_done(1'b1);
    acq_trig <= 1'b0;
  endtask

  task automatic disarm();
    @(posedge clk);
    acq_arm <= 1'b0;
    wait_done(1'b0);
  endtask

  // data words follow the counter and end at the address in header word 1
  task automatic check_data(input int n_data);
    logic [11:0] cnt;
    logic [11:0] prev;
    int          i;
    check_word("reply length", word_t'(reply.size()), word_t'(n_data + 2));
    if (reply.size() != n_data + 2) return;
    for (i = 2; i < reply.size(); i++) begin
      cnt = reply[i][12:1];
      check_word($sformatf("data word %0d", i - 2), reply[i], packed_word(cnt));
      if (i > 2) check_word("data count step", word_t'(cnt), word_t'(prev + 1'b1));
      prev = cnt;
    end
    // address 0 holds the count seen 3 clocks after the arm edge
    check_word("last address", word_t'(reply[1][ADDR_W-1:0]),
               word_t'((prev - (CNT_IDLE + 3)) % BUF_WORDS));
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////
  task automatic test_no_event();
    send_cmd(read_cmd(12'd4));
    get_reply(1'b0);
    check_word("reply length", word_t'(reply.size()), 32'd1);
    if (reply.size() > 0) check_word("status word", reply[0], STATUS_NO_EVENT);
  endtask

  task automatic test_event_header();
    send_cmd(write_cmd(REG_BUFFER_SIZE, 24'd64));
    send_cmd(write_cmd(REG_POST_TRIG, 24'd8));
    send_cmd(write_cmd(REG_CHANNEL_NUM, 24'd5));
    send_cmd(write_cmd(REG_TRIG_NUM, 24'd40));
    run_event();
    send_cmd(read_cmd(12'd12));
    get_reply(1'b0);
    check_flag("acq_done held", acq_done, 1'b1);   // done stays up while armed
    if (reply.size() < 2) begin
      $display("reply too short to hold both header words");
      errors++;
    end else begin
      check_word("header word 0", reply[0], 32'd40);
      check_word("header channel", reply[1] >> 16, 32'd5);   // channel in the top half
    end
  endtask

  task automatic test_event_data();
    check_data(12);
    saved = reply;
  endtask

  task automatic test_stall_replay();
    int i;
    disarm();
    send_cmd(write_cmd(REG_TRIG_NUM, 24'd40));   // same event number as before
    run_event();
    send_cmd(read_cmd(12'd12));
    get_reply(1'b1);
    check_word("replay length", word_t'(reply.size()), word_t'(saved.size()));
    if (reply.size() != saved.size()) return;
    for (i = 0; i < reply.size(); i++) begin
      check_word($sformatf("replay word %0d", i), reply[i], saved[i]);
    end
  endtask

  task automatic test_rearm_clamp();
    disarm();
    run_event();
    send_cmd(read_cmd(12'd300));   // more than the 64-word ring
    get_reply(1'b0);
    if (reply.size() > 0) check_word("header word 0", reply[0], 32'd41);
    check_data(BUF_WORDS);
  endtask

  task automatic report(input int num, input string name, input int errs_before);
    if (errors == errs_before) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      $display("test %0d %s: %0d errors", num, name, errors - errs_before);
      failed_tests++;
    end
  endtask

  initial begin
    int e;
    seed         = 62818;
    errors       = 0;
    failed_tests = 0;
    sample_cnt   = CNT_IDLE;
    reset        = 1'b1;
    acq_arm      = 1'b0;
    acq_trig     = 1'b0;
    rx_data      = '0;
    rx_valid     = 1'b0;
    rx_last      = 1'b0;
    tx_ready     = 1'b1;
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    e = errors;
    test_no_event();
    report(1, "status without event", e);
    e = errors;
    test_event_header();
    report(2, "event header", e);
    e = errors;
    test_event_data();
    report(3, "event data", e);
    e = errors;
    test_stall_replay();
    report(4, "replay under stalls", e);
    e = errors;
    test_rearm_clamp();
    report(5, "rearm and clamp", e);

    $display("tests run 5, failed %0d, errors %0d", failed_tests, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== build.f ====
source/chan_cfg_pkg.sv
source/chan_cmd_pkg.sv
source/command_decoder.sv
source/acq_controller.sv
source/event_store.sv
source/readout_engine.sv
source/channel_core.sv
tb/channel_core_chk.sv
tb/channel_core_tb.sv

// ==== Makefile ====
SIM  := obj_dir/Vchannel_core_tb
SRCS := $(wildcard source/*.sv tb/*.sv)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) build.f
	verilator --binary --timing --assert -Wno-fatal -f build.f \
		--top-module channel_core_tb -o Vchannel_core_tb

run: $(SIM)
	$(SIM) > sim.log 2>&1; rc=$$?; cat sim.log; \
		test $$rc -eq 0 && ! grep -q "TEST RESULT: FAIL" sim.log

clean:
	rm -rf obj_dir sim.log
